//--- Bender.yml
package:
  name: branch_unit

sources:
  - verilog/branchPkg.sv
  - verilog/branchRsEntry.sv
  - verilog/branchSelect.sv
  - verilog/branchStation.sv
  - verilog/branchResolve.sv
  - verilog/branchUnit.sv
  - target: test
    files:
      - verif/branchUnitTb.sv

//--- flist.f
verilog/branchPkg.sv
verilog/branchRsEntry.sv
verilog/branchSelect.sv
verilog/branchStation.sv
verilog/branchResolve.sv
verilog/branchUnit.sv
verif/branchUnitTb.sv

//--- verif/branchUnitTb.sv
// Branch unit testbench.
// Random dispatch and CDB traffic with flushes, checked against a model keyed by ROB tag.

module branchUnitTb;
  timeunit 1ns;
  timeprecision 1ps;
  import branchPkg::*;

  localparam int numEntries  = 4;
  localparam int numDispatch = 300;
  localparam int cycleLimit  = 10 * numDispatch + 200;

  logic       clk;
  logic       arstN;
  logic       flush;
  brDispatchT dispatch;
  cdbT        cdb;
  logic       full;
  brResultT   result;

  brDispatchT  model [16];  // in-flight branches, valid marks a live tag.
  int          inFlight;    // accepted and not yet resolved.
  int          sent;
  int          errors;
  int          checks;
  int          cycles;
  bit          driveValid;  // a dispatch is on the bus for the coming cycle.
  logic [31:0] rngState;
  string       opNames [8] = '{"beq", "bne", "blt", "bge", "bltu", "bgeu", "jal", "jalr"};

  branchUnit #(
    .numEntries(numEntries)
  ) u_dut (
    .clk      (clk),
    .arstN    (arstN),
    .flush    (flush),
    .dispatch (dispatch),
    .cdb      (cdb),
    .full     (full),
    .result   (result)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ------------------------------
  // helpers
  // ------------------------------
  function automatic logic [31:0] nextRand();
    rngState ^= rngState << 13;
    rngState ^= rngState >> 17;
    rngState ^= rngState << 5;
    return rngState;
  endfunction

  // edge values show up three times in four.
  function automatic logic [31:0] pickValue();
    logic [31:0] r;
    r = nextRand();
    case (r[1:0])
      2'd0:    return 32'h8000_0000;
      2'd1:    return 32'h7fff_ffff;
      2'd2:    return {{29{r[4]}}, r[4:2]};  // small, around zero.
      default: return nextRand();
    endcase
  endfunction

  function automatic logic expectedTaken(brDispatchT b);
    case (b.op)
      opBeq:   return b.src1Val == b.src2Val;
      opBne:   return b.src1Val != b.src2Val;
      opBlt:   return $signed(b.src1Val) < $signed(b.src2Val);
      opBge:   return $signed(b.src1Val) >= $signed(b.src2Val);
      opBltu:  return b.src1Val < b.src2Val;
      opBgeu:  return b.src1Val >= b.src2Val;
      default: return 1'b1;  // jumps.
    endcase
  endfunction

  function automatic logic [31:0] expectedNext(brDispatchT b);
    if (b.op == opJalr) begin
      return (b.src1Val + b.target) & 32'hffff_fffe;
    end
    return expectedTaken(b) ? b.target : b.seqPc;
  endfunction

  task automatic checkValue(string name, logic [31:0] expected, logic [31:0] actual);
    checks++;
    if (expected !== actual) begin
      $display("FAILED %s: expected %h, actual %h", name, expected, actual);
      errors++;
    end
  endtask

  // ------------------------------
  // checks against the model
  // ------------------------------
  // with this cycle's result counted, occupancy equals the busy entries.
  task automatic checkFull();
    logic [31:0] expected;
    expected = (inFlight >= numEntries) ? 32'd1 : 32'd0;
    checkValue("full", expected, full);
  endtask

  task automatic checkResult();
    brDispatchT b;
    string      name;
    b = model[result.robTag];
    if (!b.valid) begin
      $display("ERROR: result for tag %0d with no branch in flight", result.robTag);
      errors++;
    end else begin
      if (!(b.src1Ready && b.src2Ready)) begin
        $display("ERROR: result for tag %0d before its operands arrived", result.robTag);
        errors++;
      end
      name = $sformatf("%s tag %0d", opNames[b.op], b.robTag);
      checkValue({name, " taken"}, expectedTaken(b), result.taken);
      checkValue({name, " nextPc"}, expectedNext(b), result.nextPc);
      checkValue({name, " link"}, b.seqPc, result.link);
      checkValue({name, " mispredict"}, expectedNext(b) != b.predPc, result.mispredict);
      model[result.robTag].valid = 1'b0;
      inFlight--;
    end
  endtask

  task automatic updateModel();
    if (flush) begin
      for (int t = 0; t < 16; t++) begin
        model[t].valid = 1'b0;  // unissued work is gone.
      end
      inFlight = 0;
    end else begin
      if (dispatch.valid && !full) begin
        model[dispatch.robTag] = dispatch;
        inFlight++;
      end
      if (cdb.valid) begin
        for (int t = 0; t < 16; t++) begin
          if (model[t].valid && !model[t].src1Ready && model[t].src1Tag == cdb.robTag) begin
            model[t].src1Val   = cdb.value;
            model[t].src1Ready = 1'b1;
          end
          if (model[t].valid && !model[t].src2Ready && model[t].src2Tag == cdb.robTag) begin
            model[t].src2Val   = cdb.value;
            model[t].src2Ready = 1'b1;
          end
        end
      end
    end
  endtask

  // ------------------------------
  // stimulus
  // ------------------------------
  task automatic driveNext();
    brDispatchT  d;
    cdbT         c;
    logic        f;
    logic [31:0] r;
    logic [31:0] pc;
    logic [31:0] offset;
    int          tag;
    d = '0;
    c = '0;
    r = nextRand();
    if (sent < numDispatch && inFlight < numEntries && r[2:0] < 3'd5) begin
      tag = r[5:3];
      while (model[tag].valid) begin
        tag = (tag + 1) % 8;  // branch tags live in 0..7.
      end
      pc          = nextRand() & 32'hffff_fffc;
      offset      = {{20{r[27]}}, r[27:16]};
      d.valid     = 1'b1;
      d.op        = brOpT'(r[8:6]);
      d.robTag    = tag;
      d.src1Ready = r[9];
      d.src1Tag   = {1'b1, r[12:10]};  // producers live in 8..15.
      d.src1Val   = pickValue();
      d.src2Ready = r[13];
      d.src2Tag   = {1'b1, r[30:28]};
      d.src2Val   = r[14] ? d.src1Val : pickValue();
      d.seqPc     = pc + 32'd4;
      d.target    = (d.op == opJalr) ? offset : pc + (offset << 1);
      if (r[15] && d.src1Ready && d.src2Ready) begin
        d.predPc = expectedNext(d);
      end else begin
        d.predPc = r[31] ? d.target : d.seqPc;
      end
      sent++;
    end
    f = (sent < numDispatch) && (nextRand() % 50 == 0);
    r = nextRand();
    if (r[1:0] != 2'd0) begin
      c.valid  = 1'b1;
      c.robTag = {1'b1, r[4:2]};
      c.value  = pickValue();
      if (d.valid && !d.src2Ready && r[5]) begin
        c.robTag = d.src2Tag;  // beat lands with the dispatch.
      end
    end
    dispatch   <= d;
    cdb        <= c;
    flush      <= f;
    driveValid = d.valid;
  endtask

  // ------------------------------
  // main sequence
  // ------------------------------
  initial begin
    arstN      = 1'b0;
    flush      = 1'b0;
    dispatch   = '0;
    cdb        = '0;
    rngState   = 32'd74139;
    inFlight   = 0;
    sent       = 0;
    errors     = 0;
    checks     = 0;
    cycles     = 0;
    driveValid = 1'b0;
    for (int t = 0; t < 16; t++) begin
      model[t] = '0;
    end
    repeat (4) @(posedge clk);
    checkValue("reset full", 32'd0, full);
    checkValue("reset result valid", 32'd0, result.valid);
    arstN <= 1'b1;
    while ((sent < numDispatch || inFlight > 0 || driveValid) && cycles < cycleLimit) begin
      @(posedge clk);
      cycles++;
      if (result.valid) begin
        checkResult();
      end
      checkFull();
      updateModel();
      driveNext();
    end
    if (cycles >= cycleLimit) begin
      $display("ERROR: timeout after %0d cycles with %0d branches in flight", cycles, inFlight);
      errors++;
    end
    // quiet tail, nothing more may come out.
    repeat (4) begin
      @(posedge clk);
      if (result.valid) begin
        checkResult();
      end
    end
    if (inFlight != 0) begin
      $display("ERROR: %0d branches never produced a result", inFlight);
      errors++;
    end
    $display("dispatched %0d, checks %0d, errors %0d", sent, checks, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

//--- verilog/branchPkg.sv
// Branch unit shared types.
// Operation encoding, CDB beat, dispatch, issue and result records.

package branchPkg;

  localparam int xlen = 32;  // data and address width.
  localparam int robW = 4;   // reorder-buffer tag width.

  typedef enum logic [2:0] {
    opBeq  = 3'd0,
    opBne  = 3'd1,
    opBlt  = 3'd2,
    opBge  = 3'd3,
    opBltu = 3'd4,
    opBgeu = 3'd5,
    opJal  = 3'd6,
    opJalr = 3'd7
  } brOpT;

  // ------------------------------
  // broadcast and dispatch
  // ------------------------------
  typedef struct packed {
    logic            valid;
    logic [robW-1:0] robTag;   // producer tag.
    logic [xlen-1:0] value;    // produced result.
  } cdbT;

  typedef struct packed {
    logic            valid;
    brOpT            op;
    logic [robW-1:0] robTag;     // tag of the branch itself.
    logic            src1Ready;
    logic [robW-1:0] src1Tag;    // producer of src1 when not ready.
    logic [xlen-1:0] src1Val;
    logic            src2Ready;
    logic [robW-1:0] src2Tag;
    logic [xlen-1:0] src2Val;
    logic [xlen-1:0] predPc;     // predicted next pc.
    logic [xlen-1:0] target;     // branch/jal target, jalr offset.
    logic [xlen-1:0] seqPc;      // pc + 4.
  } brDispatchT;

  // ------------------------------
  // issue and result
  // ------------------------------
  typedef struct packed {
    logic            valid;
    brOpT            op;
    logic [robW-1:0] robTag;
    logic [xlen-1:0] src1;
    logic [xlen-1:0] src2;
    logic [xlen-1:0] predPc;
    logic [xlen-1:0] target;
    logic [xlen-1:0] seqPc;
  } brIssueT;

  typedef struct packed {
    logic            valid;
    logic [robW-1:0] robTag;
    logic            taken;
    logic            mispredict;
    logic [xlen-1:0] nextPc;     // resolved next pc.
    logic [xlen-1:0] link;       // return address for jal/jalr.
  } brResultT;

endpackage

//--- verilog/branchResolve.sv
// Branch resolve stage.
// Evaluates direction and next pc, flags a misprediction and registers the result.

module branchResolve (
  input  logic               clk,
  input  logic               arstN,
  input  branchPkg::brIssueT issue,
  output branchPkg::brResultT result
);
  import branchPkg::*;

  logic            isEq;
  logic            isLt;   // signed less-than.
  logic            isLtu;  // unsigned less-than.
  logic            taken;
  logic [xlen-1:0] jalrPc;
  logic [xlen-1:0] nextPc;

  // ------------------------------
  // direction and target
  // ------------------------------
  assign isEq   = issue.src1 == issue.src2;
  assign isLt   = $signed(issue.src1) < $signed(issue.src2);
  assign isLtu  = issue.src1 < issue.src2;
  assign jalrPc = (issue.src1 + issue.target) & ~xlen'(1);  // bit 0 cleared.

  always_comb begin
    case (issue.op)
      opBeq:   taken = isEq;
      opBne:   taken = ~isEq;
      opBlt:   taken = isLt;
      opBge:   taken = ~isLt;
      opBltu:  taken = isLtu;
      opBgeu:  taken = ~isLtu;
      default: taken = 1'b1;  // jal and jalr.
    endcase
    if (issue.op == opJalr) begin
      nextPc = jalrPc;
    end else begin
      nextPc = taken ? issue.target : issue.seqPc;
    end
  end

  // result register
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      result.valid <= 1'b0;
    end else begin
      result.valid <= issue.valid;  // one cycle per issue.
      if (issue.valid) begin
        result.robTag     <= issue.robTag;
        result.taken      <= taken;
        result.mispredict <= nextPc != issue.predPc;
        result.nextPc     <= nextPc;
        result.link       <= issue.seqPc;
      end
    end
  end

endmodule

//--- verilog/branchRsEntry.sv
// Branch reservation-station entry.
// Holds one branch, wakes its operands from the CDB and requests issue.

module branchRsEntry (
  input  logic                  clk,
  input  logic                  arstN,
  input  logic                  flush,
  input  logic                  write,
  input  branchPkg::brDispatchT writeData,
  input  branchPkg::cdbT        cdb,
  input  logic                  grant,
  output logic                  busy,
  output logic                  selectReq,
  output branchPkg::brIssueT    entry
);
  import branchPkg::*;

  logic            src1Ready;  // operand already captured.
  logic            src2Ready;
  logic [robW-1:0] src1Tag;
  logic [robW-1:0] src2Tag;
  logic [xlen-1:0] src1Val;
  logic [xlen-1:0] src2Val;
  brOpT            op;
  logic [robW-1:0] robTag;
  logic [xlen-1:0] predPc;
  logic [xlen-1:0] target;
  logic [xlen-1:0] seqPc;
  logic            match1;     // cdb delivers a stored pending operand.
  logic            match2;
  logic            wrMatch1;   // cdb delivers an operand of the incoming dispatch.
  logic            wrMatch2;

  // ------------------------------
  // tag compare
  // ------------------------------
  assign match1 = busy & ~src1Ready & cdb.valid & (cdb.robTag == src1Tag);
  assign match2 = busy & ~src2Ready & cdb.valid & (cdb.robTag == src2Tag);

  assign wrMatch1 = ~writeData.src1Ready & cdb.valid & (cdb.robTag == writeData.src1Tag);
  assign wrMatch2 = ~writeData.src2Ready & cdb.valid & (cdb.robTag == writeData.src2Tag);

  // a beat in this cycle is enough to issue now.
  assign selectReq = busy & (src1Ready | match1) & (src2Ready | match2);

  always_comb begin
    entry        = '0;
    entry.valid  = busy;
    entry.op     = op;
    entry.robTag = robTag;
    entry.src1   = match1 ? cdb.value : src1Val;  // forward the beat.
    entry.src2   = match2 ? cdb.value : src2Val;
    entry.predPc = predPc;
    entry.target = target;
    entry.seqPc  = seqPc;
  end

  // ------------------------------
  // control state
  // ------------------------------
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      busy      <= 1'b0;
      src1Ready <= 1'b0;
      src2Ready <= 1'b0;
    end else if (flush) begin
      busy      <= 1'b0;  // drop whatever is held.
      src1Ready <= 1'b0;
      src2Ready <= 1'b0;
    end else if (write) begin
      busy      <= 1'b1;
      src1Ready <= writeData.src1Ready | wrMatch1;
      src2Ready <= writeData.src2Ready | wrMatch2;
    end else begin
      if (grant) begin
        busy <= 1'b0;  // leaves at the end of the issue cycle.
      end
      if (match1) begin
        src1Ready <= 1'b1;
      end
      if (match2) begin
        src2Ready <= 1'b1;
      end
    end
  end

  // payload
  always_ff @(posedge clk) begin
    if (write) begin
      op      <= writeData.op;
      robTag  <= writeData.robTag;
      src1Tag <= writeData.src1Tag;
      src2Tag <= writeData.src2Tag;
      src1Val <= wrMatch1 ? cdb.value : writeData.src1Val;
      src2Val <= wrMatch2 ? cdb.value : writeData.src2Val;
      predPc  <= writeData.predPc;
      target  <= writeData.target;
      seqPc   <= writeData.seqPc;
    end else begin
      if (match1) begin
        src1Val <= cdb.value;
      end
      if (match2) begin
        src2Val <= cdb.value;
      end
    end
  end

endmodule

//--- verilog/branchSelect.sv
// Branch station select logic.
// Lowest-index grant among requesters, lowest-index allocation among free entries.

module branchSelect #(
  parameter int numEntries = 4
) (
  input  logic [numEntries-1:0] busy,
  input  logic [numEntries-1:0] request,
  output logic [numEntries-1:0] alloc,
  output logic [numEntries-1:0] grant
);

  logic grantFound;  // a lower entry already won.
  logic allocFound;

  // ------------------------------
  // priority encoders
  // ------------------------------
  always_comb begin
    grant      = '0;
    alloc      = '0;
    grantFound = 1'b0;
    allocFound = 1'b0;
    for (int i = 0; i < numEntries; i++) begin
      if (request[i] && !grantFound) begin
        grant[i]   = 1'b1;  // oldest slot is not implied, index order only.
        grantFound = 1'b1;
      end
      if (!busy[i] && !allocFound) begin
        alloc[i]   = 1'b1;
        allocFound = 1'b1;
      end
    end
  end

endmodule

//--- verilog/branchStation.sv
// Branch reservation station.
// Entry array with dispatch steering, issue mux and the full flag.

module branchStation #(
  parameter int numEntries = 4
) (
  input  logic                  clk,
  input  logic                  arstN,
  input  logic                  flush,
  input  branchPkg::brDispatchT dispatch,
  input  branchPkg::cdbT        cdb,
  output logic                  full,
  output branchPkg::brIssueT    issue
);
  import branchPkg::*;

  logic [numEntries-1:0] busyVec;   // per-entry occupancy.
  logic [numEntries-1:0] reqVec;    // per-entry issue request.
  logic [numEntries-1:0] allocVec;  // one-hot free slot.
  logic [numEntries-1:0] grantVec;  // one-hot issue winner.
  logic [numEntries-1:0] writeVec;
  logic                  accept;
  brIssueT               entryVec [numEntries];

  // ------------------------------
  // dispatch steering
  // ------------------------------
  assign full     = &busyVec;
  assign accept   = dispatch.valid & ~full & ~flush;  // dropped when full.
  assign writeVec = allocVec & {numEntries{accept}};

  branchSelect #(
    .numEntries(numEntries)
  ) u_select (
    .busy    (busyVec),
    .request (reqVec),
    .alloc   (allocVec),
    .grant   (grantVec)
  );

  for (genvar i = 0; i < numEntries; i++) begin : gEntry
    branchRsEntry u_entry (
      .clk       (clk),
      .arstN     (arstN),
      .flush     (flush),
      .write     (writeVec[i]),
      .writeData (dispatch),
      .cdb       (cdb),
      .grant     (grantVec[i]),
      .busy      (busyVec[i]),
      .selectReq (reqVec[i]),
      .entry     (entryVec[i])
    );
  end

  // ------------------------------
  // issue mux
  // ------------------------------
  // grant is one-hot so at most one entry is picked here.
  always_comb begin
    issue = '0;
    for (int i = 0; i < numEntries; i++) begin
      if (grantVec[i]) begin
        issue = entryVec[i];
      end
    end
    issue.valid = (|grantVec) & ~flush;  // nothing leaves in a flush cycle.
  end

endmodule

//--- verilog/branchUnit.sv
// Branch unit top level.
// Reservation station feeding the resolve stage.

module branchUnit #(
  parameter int numEntries = 4
) (
  input  logic                  clk,
  input  logic                  arstN,
  input  logic                  flush,
  input  branchPkg::brDispatchT dispatch,
  input  branchPkg::cdbT        cdb,
  output logic                  full,
  output branchPkg::brResultT   result
);
  import branchPkg::*;

  brIssueT issueBus;  // station to resolver.

  // ------------------------------
  // station
  // ------------------------------
  branchStation #(
    .numEntries(numEntries)
  ) u_station (
    .clk      (clk),
    .arstN    (arstN),
    .flush    (flush),
    .dispatch (dispatch),
    .cdb      (cdb),
    .full     (full),
    .issue    (issueBus)
  );

  // ------------------------------
  // resolve
  // ------------------------------
  branchResolve u_resolve (
    .clk    (clk),
    .arstN  (arstN),
    .issue  (issueBus),
    .result (result)
  );

endmodule
